/* design/csum_engine.sv */
`timescale 1ns/10ps

module csum_engine
(
   input  logic                    mm2s_clk,
   input  logic                    rst,
   input  logic                    beat_valid,
   input  tx_csum_pkg::beat_data_t beat_data,
   input  tx_csum_pkg::beat_keep_t beat_keep,
   input  logic                    beat_last,
   input  logic                    cs_enable,
   input  tx_csum_pkg::byte_off_t  cs_begin,
   input  tx_csum_pkg::byte_off_t  cs_insert,
   input  tx_csum_pkg::csum_t      cs_init,
   output logic                    engine_ready,
   output logic                    frame_done,
   output logic                    result_valid,
   output tx_csum_pkg::csum_t      result,
   output logic                    result_enable,
   output tx_csum_pkg::byte_off_t  result_insert,
   input  logic                    result_take
);

   tx_csum_pkg::beat_cnt_t beat_cnt;
   tx_csum_pkg::csum_acc_t acc;
   tx_csum_pkg::csum_acc_t beat_sum;
   tx_csum_pkg::csum_acc_t total_q;
   tx_csum_pkg::csum_acc_t fold_q;
   logic                   cmpl_pend;
   logic                   en_q;
   tx_csum_pkg::byte_off_t ins_q;

   // Four 16-bit words per beat, even lane is the high byte
   always_comb
   begin : pair_sum
      tx_csum_pkg::byte_off_t base;
      tx_csum_pkg::byte_off_t off_hi;
      tx_csum_pkg::byte_off_t off_lo;
      logic [7:0]             hi;
      logic [7:0]             lo;
      base     = {beat_cnt, 3'b000};
      beat_sum = '0;
      for (int p = 0; p < 4; p++)
      begin
         off_hi = base + 16'(2 * p);
         off_lo = off_hi + 16'd1;
         hi = (beat_keep[2*p] && (off_hi >= cs_begin)) ? beat_data[16*p +: 8] : 8'h00;
         lo = (beat_keep[2*p+1] && (off_lo >= cs_begin)) ? beat_data[16*p+8 +: 8] : 8'h00;
         beat_sum = beat_sum + {16'h0000, hi, lo};
      end
   end

   // Busy while the fold pipeline runs or a result waits
   assign engine_ready = !result_valid && !frame_done && !cmpl_pend;

   always_ff @(posedge mm2s_clk)
   begin
      if (rst)
      begin
         beat_cnt     <= '0;
         acc          <= '0;
         frame_done   <= 1'b0;
         cmpl_pend    <= 1'b0;
         result_valid <= 1'b0;
      end
      else
      begin
         frame_done <= beat_valid && beat_last;
         cmpl_pend  <= frame_done;
         if (beat_valid)
         begin
            if (beat_last)
            begin
               beat_cnt <= '0;
               acc      <= '0;
            end
            else
            begin
               beat_cnt <= beat_cnt + 1'b1;
               acc      <= acc + beat_sum;
            end
         end
         if (cmpl_pend)
            result_valid <= 1'b1;
         else if (result_take)
            result_valid <= 1'b0;
      end
   end

   // Total, first fold, then second fold with complement
   always_ff @(posedge mm2s_clk)
   begin
      if (beat_valid && beat_last)
      begin
         total_q <= acc + beat_sum + {16'h0000, cs_init};
         en_q    <= cs_enable;
         ins_q   <= cs_insert;
      end
      if (frame_done)
         fold_q <= {16'h0000, total_q[31:16]} + {16'h0000, total_q[15:0]};
      if (cmpl_pend)
      begin
         // First fold tops out at 0x1fffe, so this add cannot carry
         result        <= ~tx_csum_pkg::csum_t'(fold_q[15:0] + fold_q[31:16]);
         result_enable <= en_q;
         result_insert <= ins_q;
      end
   end

endmodule

/* design/frame_buffer.sv */
`timescale 1ns/10ps
`include "tx_csum_config.svh"

module frame_buffer
(
   input  logic                    mm2s_clk,
   input  logic                    rst,
   input  logic                    wr_en,
   input  tx_csum_pkg::beat_data_t wr_data,
   input  tx_csum_pkg::beat_keep_t wr_keep,
   input  logic                    wr_last,
   output logic                    full,
   input  logic                    rd_en,
   output tx_csum_pkg::beat_data_t rd_data,
   output tx_csum_pkg::beat_keep_t rd_keep,
   output logic                    rd_last,
   output logic                    empty
);

   tx_csum_pkg::beat_data_t data_mem [`TXC_BUF_DEPTH];
   tx_csum_pkg::beat_keep_t keep_mem [`TXC_BUF_DEPTH];
   logic                    last_mem [`TXC_BUF_DEPTH];

   logic [`TXC_BUF_AW-1:0] wr_ptr;
   logic [`TXC_BUF_AW-1:0] rd_ptr;
   logic [`TXC_BUF_AW:0]   count;
   logic                   do_wr;
   logic                   do_rd;

   assign full  = (count == (`TXC_BUF_AW+1)'(`TXC_BUF_DEPTH));
   assign empty = (count == '0);

   // Requests against a full or empty buffer are dropped
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge mm2s_clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (do_wr)
      begin
         data_mem[wr_ptr] <= wr_data;
         keep_mem[wr_ptr] <= wr_keep;
         last_mem[wr_ptr] <= wr_last;
      end
   end

   // Registered read port, data valid the cycle after rd_en
   always_ff @(posedge mm2s_clk)
   begin
      if (do_rd)
      begin
         rd_data <= data_mem[rd_ptr];
         rd_keep <= keep_mem[rd_ptr];
         rd_last <= last_mem[rd_ptr];
      end
   end

endmodule

/* design/frame_emitter.sv */
`timescale 1ns/10ps

module frame_emitter
(
   input  logic                    mm2s_clk,
   input  logic                    rst,
   input  logic                    result_valid,
   input  tx_csum_pkg::csum_t      result,
   input  logic                    result_enable,
   input  tx_csum_pkg::byte_off_t  result_insert,
   output logic                    result_take,
   output logic                    rd_en,
   input  tx_csum_pkg::beat_data_t rd_data,
   input  tx_csum_pkg::beat_keep_t rd_keep,
   input  logic                    rd_last,
   input  logic                    empty,
   output tx_csum_pkg::beat_data_t tx_axis_mac_tdata,
   output tx_csum_pkg::beat_keep_t tx_axis_mac_tkeep,
   output logic                    tx_axis_mac_tlast,
   output logic                    tx_axis_mac_tvalid,
   input  logic                    tx_axis_mac_tready
);

   tx_csum_pkg::emit_state_t state;
   tx_csum_pkg::beat_cnt_t   beat_idx;
   tx_csum_pkg::csum_t       csum_q;
   logic                     en_q;
   tx_csum_pkg::byte_off_t   ins_q;
   tx_csum_pkg::beat_data_t  patched;
   logic                     take;
   logic                     load;

   // Frame is already whole in the buffer once its result shows up
   assign take        = (state == tx_csum_pkg::idle) && result_valid && !empty;
   assign result_take = take;

   // In prime and stream, rd_data always holds the next unsent beat
   assign load  = (state != tx_csum_pkg::idle) && (!tx_axis_mac_tvalid || tx_axis_mac_tready);
   assign rd_en = take || (load && !rd_last);

   // Checksum goes big endian into two adjacent lanes
   always_comb
   begin : patch
      logic [2:0] lane;
      lane    = ins_q[2:0];
      patched = rd_data;
      if (en_q && (beat_idx == ins_q[15:3]))
      begin
         patched[8*lane +: 8]     = csum_q[15:8];
         patched[8*lane + 8 +: 8] = csum_q[7:0];
      end
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (rst)
      begin
         state              <= tx_csum_pkg::idle;
         beat_idx           <= '0;
         tx_axis_mac_tvalid <= 1'b0;
      end
      else
      begin
         case (state)
            tx_csum_pkg::idle:
               if (take)
                  state <= tx_csum_pkg::prime;
            tx_csum_pkg::prime:
               if (load)
                  state <= rd_last ? tx_csum_pkg::idle : tx_csum_pkg::stream;
            tx_csum_pkg::stream:
               if (load && rd_last)
                  state <= tx_csum_pkg::idle;
            default:
               state <= tx_csum_pkg::idle;
         endcase

         if (take)
            beat_idx <= '0;
         else if (load)
            beat_idx <= beat_idx + 1'b1;

         if (load)
            tx_axis_mac_tvalid <= 1'b1;
         else if (tx_axis_mac_tready)
            tx_axis_mac_tvalid <= 1'b0;
      end
   end

   always_ff @(posedge mm2s_clk)
   begin
      if (take)
      begin
         csum_q <= result;
         en_q   <= result_enable;
         ins_q  <= result_insert;
      end
      if (load)
      begin
         tx_axis_mac_tdata <= patched;
         tx_axis_mac_tkeep <= rd_keep;
         tx_axis_mac_tlast <= rd_last;
      end
   end

endmodule

/* design/tx_csum_config.svh */
`ifndef TX_CSUM_CONFIG_SVH
`define TX_CSUM_CONFIG_SVH

// Frame buffer geometry in 64-bit beats
`define TXC_BUF_DEPTH 512
`define TXC_BUF_AW 9

// Control words per frame descriptor
`define TXC_CTRL_WORDS 6

// Flag nibble expected in word 0, bits 31:28
`define TXC_FLAG 4'hA

// Checksum control code in word 1 that requests insertion
// Any other code leaves the frame untouched
`define TXC_CS_FULL 2'b01

`endif

/* design/tx_csum_offload.sv */
`timescale 1ns/10ps

module tx_csum_offload
(
   input  logic                    mm2s_clk,
   input  logic                    rst,
   input  tx_csum_pkg::ctrl_word_t txc_tdata,
   input  logic [3:0]              txc_tkeep,
   input  logic                    txc_tlast,
   input  logic                    txc_tvalid,
   output logic                    txc_tready,
   input  tx_csum_pkg::beat_data_t txd_tdata,
   input  tx_csum_pkg::beat_keep_t txd_tkeep,
   input  logic                    txd_tlast,
   input  logic                    txd_tvalid,
   output logic                    txd_tready,
   output tx_csum_pkg::beat_data_t tx_axis_mac_tdata,
   output tx_csum_pkg::beat_keep_t tx_axis_mac_tkeep,
   output logic                    tx_axis_mac_tlast,
   output logic                    tx_axis_mac_tvalid,
   input  logic                    tx_axis_mac_tready
);

   tx_csum_pkg::ctrl_word_t ctrl_word;
   logic                    params_valid;
   logic                    cs_enable;
   tx_csum_pkg::byte_off_t  cs_begin;
   tx_csum_pkg::byte_off_t  cs_insert;
   tx_csum_pkg::csum_t      cs_init;
   logic                    engine_ready;
   logic                    frame_done;
   logic                    buffer_full;
   logic                    beat_acc;
   logic                    result_valid;
   tx_csum_pkg::csum_t      result;
   logic                    result_enable;
   tx_csum_pkg::byte_off_t  result_insert;
   logic                    result_take;
   logic                    rd_en;
   tx_csum_pkg::beat_data_t rd_data;
   tx_csum_pkg::beat_keep_t rd_keep;
   logic                    rd_last;
   logic                    buffer_empty;

   // Bytes without keep read as zero
   assign ctrl_word = txc_tdata & {{8{txc_tkeep[3]}}, {8{txc_tkeep[2]}},
                                   {8{txc_tkeep[1]}}, {8{txc_tkeep[0]}}};

   // Beats flow only with a descriptor in hand, engine free and room left
   assign txd_tready = params_valid && engine_ready && !buffer_full;
   assign beat_acc   = txd_tvalid && txd_tready;

   txc_parser i_txc_parser
   (
      .mm2s_clk     (mm2s_clk),
      .rst          (rst),
      .txc_tdata    (ctrl_word),
      .txc_tvalid   (txc_tvalid),
      .txc_tlast    (txc_tlast),
      .txc_tready   (txc_tready),
      .frame_done   (frame_done),
      .params_valid (params_valid),
      .cs_enable    (cs_enable),
      .cs_begin     (cs_begin),
      .cs_insert    (cs_insert),
      .cs_init      (cs_init)
   );

   frame_buffer i_frame_buffer
   (
      .mm2s_clk (mm2s_clk),
      .rst      (rst),
      .wr_en    (beat_acc),
      .wr_data  (txd_tdata),
      .wr_keep  (txd_tkeep),
      .wr_last  (txd_tlast),
      .full     (buffer_full),
      .rd_en    (rd_en),
      .rd_data  (rd_data),
      .rd_keep  (rd_keep),
      .rd_last  (rd_last),
      .empty    (buffer_empty)
   );

   csum_engine i_csum_engine
   (
      .mm2s_clk      (mm2s_clk),
      .rst           (rst),
      .beat_valid    (beat_acc),
      .beat_data     (txd_tdata),
      .beat_keep     (txd_tkeep),
      .beat_last     (txd_tlast),
      .cs_enable     (cs_enable),
      .cs_begin      (cs_begin),
      .cs_insert     (cs_insert),
      .cs_init       (cs_init),
      .engine_ready  (engine_ready),
      .frame_done    (frame_done),
      .result_valid  (result_valid),
      .result        (result),
      .result_enable (result_enable),
      .result_insert (result_insert),
      .result_take   (result_take)
   );

   frame_emitter i_frame_emitter
   (
      .mm2s_clk           (mm2s_clk),
      .rst                (rst),
      .result_valid       (result_valid),
      .result             (result),
      .result_enable      (result_enable),
      .result_insert      (result_insert),
      .result_take        (result_take),
      .rd_en              (rd_en),
      .rd_data            (rd_data),
      .rd_keep            (rd_keep),
      .rd_last            (rd_last),
      .empty              (buffer_empty),
      .tx_axis_mac_tdata  (tx_axis_mac_tdata),
      .tx_axis_mac_tkeep  (tx_axis_mac_tkeep),
      .tx_axis_mac_tlast  (tx_axis_mac_tlast),
      .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
      .tx_axis_mac_tready (tx_axis_mac_tready)
   );

endmodule

/* design/tx_csum_pkg.sv */
package tx_csum_pkg;

   // One data beat, byte 0 of the beat in bits 7:0
   typedef logic [63:0] beat_data_t;

   // One keep bit per byte lane
   typedef logic [7:0] beat_keep_t;

   // Control stream word
   typedef logic [31:0] ctrl_word_t;

   // Byte position within a frame
   typedef logic [15:0] byte_off_t;

   // Checksum value or partial sum
   typedef logic [15:0] csum_t;

   // Wide running sum, carries kept until the fold
   typedef logic [31:0] csum_acc_t;

   // Beat index within a frame
   typedef logic [12:0] beat_cnt_t;

   typedef enum logic
   {
      collect,
      hold
   } parser_state_t;

   typedef enum logic [1:0]
   {
      idle,
      prime,
      stream
   } emit_state_t;

endpackage

/* design/txc_parser.sv */
`timescale 1ns/10ps
`include "tx_csum_config.svh"

module txc_parser
(
   input  logic                   mm2s_clk,
   input  logic                   rst,
   input  tx_csum_pkg::ctrl_word_t txc_tdata,
   input  logic                   txc_tvalid,
   input  logic                   txc_tlast,
   output logic                   txc_tready,
   input  logic                   frame_done,
   output logic                   params_valid,
   output logic                   cs_enable,
   output tx_csum_pkg::byte_off_t cs_begin,
   output tx_csum_pkg::byte_off_t cs_insert,
   output tx_csum_pkg::csum_t     cs_init
);

   tx_csum_pkg::parser_state_t state;
   logic [2:0] word_cnt;
   logic       flag_ok;
   logic [1:0] cs_mode;
   logic       word_acc;
   logic       word_end;

   assign txc_tready = (state == tx_csum_pkg::collect);
   assign word_acc   = txc_tvalid && txc_tready;

   // tlast normally closes the descriptor, the count is a backstop
   assign word_end = txc_tlast || (word_cnt == 3'(`TXC_CTRL_WORDS - 1));

   assign cs_enable = flag_ok && (cs_mode == `TXC_CS_FULL);

   always_ff @(posedge mm2s_clk)
   begin
      if (rst)
      begin
         state        <= tx_csum_pkg::collect;
         word_cnt     <= 3'd0;
         params_valid <= 1'b0;
         flag_ok      <= 1'b0;
         cs_mode      <= 2'b00;
      end
      else
      begin
         case (state)
            tx_csum_pkg::collect:
            begin
               if (word_acc)
               begin
                  if (word_cnt == 3'd0)
                     flag_ok <= (txc_tdata[31:28] == `TXC_FLAG);
                  if (word_cnt == 3'd1)
                     cs_mode <= txc_tdata[1:0];
                  if (word_end)
                  begin
                     state        <= tx_csum_pkg::hold;
                     word_cnt     <= 3'd0;
                     params_valid <= 1'b1;
                  end
                  else
                     word_cnt <= word_cnt + 3'd1;
               end
            end
            tx_csum_pkg::hold:
            begin
               // Parameters stay put until the engine has seen the whole frame
               if (frame_done)
               begin
                  state        <= tx_csum_pkg::collect;
                  params_valid <= 1'b0;
               end
            end
            default:
               state <= tx_csum_pkg::collect;
         endcase
      end
   end

   // Offsets and initial sum
   always_ff @(posedge mm2s_clk)
   begin
      if (word_acc && (word_cnt == 3'd2))
      begin
         cs_begin  <= txc_tdata[31:16];
         cs_insert <= txc_tdata[15:0];
      end
      if (word_acc && (word_cnt == 3'd3))
         cs_init <= txc_tdata[15:0];
   end

endmodule

/* dv/tx_csum_offload_assertions.sv */
`timescale 1ns/10ps

module tx_csum_offload_assertions
(
   input logic                    mm2s_clk,
   input logic                    rst,
   input logic                    rd_en,
   input logic                    empty,
   input tx_csum_pkg::beat_data_t tx_axis_mac_tdata,
   input tx_csum_pkg::beat_keep_t tx_axis_mac_tkeep,
   input logic                    tx_axis_mac_tlast,
   input logic                    tx_axis_mac_tvalid,
   input logic                    tx_axis_mac_tready
);

   int fail_cnt = 0;

   // A stalled beat stays on the bus unchanged
   property hold_under_stall;
      @(posedge mm2s_clk) disable iff (rst)
      (tx_axis_mac_tvalid && !tx_axis_mac_tready) |=>
         (tx_axis_mac_tvalid && $stable(tx_axis_mac_tdata) &&
          $stable(tx_axis_mac_tkeep) && $stable(tx_axis_mac_tlast));
   endproperty

   property no_read_when_empty;
      @(posedge mm2s_clk) disable iff (rst)
      rd_en |-> !empty;
   endproperty

   stall_hold: assert property (hold_under_stall)
   else
   begin
      $error("MAC output changed or dropped valid while stalled");
      fail_cnt++;
   end

   read_guard: assert property (no_read_when_empty)
   else
   begin
      $error("buffer read issued while empty");
      fail_cnt++;
   end

endmodule

bind frame_emitter tx_csum_offload_assertions i_emitter_assertions
(
   .mm2s_clk           (mm2s_clk),
   .rst                (rst),
   .rd_en              (rd_en),
   .empty              (empty),
   .tx_axis_mac_tdata  (tx_axis_mac_tdata),
   .tx_axis_mac_tkeep  (tx_axis_mac_tkeep),
   .tx_axis_mac_tlast  (tx_axis_mac_tlast),
   .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
   .tx_axis_mac_tready (tx_axis_mac_tready)
);

/* dv/tx_csum_offload_tb.sv */
`timescale 1ns/10ps
`include "tx_csum_config.svh"

module tx_csum_offload_tb;

   localparam int NUM_TESTS = 14;

   logic                    mm2s_clk;
   logic                    rst;
   tx_csum_pkg::ctrl_word_t txc_tdata;
   logic [3:0]              txc_tkeep;
   logic                    txc_tlast;
   logic                    txc_tvalid;
   logic                    txc_tready;
   tx_csum_pkg::beat_data_t txd_tdata;
   tx_csum_pkg::beat_keep_t txd_tkeep;
   logic                    txd_tlast;
   logic                    txd_tvalid;
   logic                    txd_tready;
   tx_csum_pkg::beat_data_t tx_axis_mac_tdata;
   tx_csum_pkg::beat_keep_t tx_axis_mac_tkeep;
   logic                    tx_axis_mac_tlast;
   logic                    tx_axis_mac_tvalid;
   logic                    tx_axis_mac_tready;

   // Frame table, one column per array
   string      test_name  [NUM_TESTS];
   logic [3:0] flag_tab   [NUM_TESTS];
   logic [1:0] code_tab   [NUM_TESTS];
   int         begin_tab  [NUM_TESTS];
   int         insert_tab [NUM_TESTS];
   logic [15:0] init_tab  [NUM_TESTS];
   int         len_tab    [NUM_TESTS];
   bit         bp_tab     [NUM_TESTS];
   int         beats_tab  [NUM_TESTS];
   int         err_tab    [NUM_TESTS];

   logic [31:0] lfsr_state = 32'h3b03_5556;
   logic [7:0]  frame_bytes [`TXC_BUF_DEPTH*8];

   tx_csum_pkg::beat_data_t in_data [$];
   tx_csum_pkg::beat_keep_t in_keep [$];
   logic                    in_last [$];
   tx_csum_pkg::beat_data_t exp_data [$];
   tx_csum_pkg::beat_keep_t exp_keep [$];
   logic                    exp_last [$];
   tx_csum_pkg::beat_data_t want_data;
   tx_csum_pkg::beat_keep_t want_keep;
   logic                    want_last;

   int timeout_limit;
   int cycle_cnt = 0;
   int out_frame = 0;
   int out_beat = 0;
   int error_cnt = 0;
   int check_cnt = 0;
   int stall_cycles = 0;
   int total_beats = 0;

   tx_csum_offload i_tx_csum_offload
   (
      .mm2s_clk           (mm2s_clk),
      .rst                (rst),
      .txc_tdata          (txc_tdata),
      .txc_tkeep          (txc_tkeep),
      .txc_tlast          (txc_tlast),
      .txc_tvalid         (txc_tvalid),
      .txc_tready         (txc_tready),
      .txd_tdata          (txd_tdata),
      .txd_tkeep          (txd_tkeep),
      .txd_tlast          (txd_tlast),
      .txd_tvalid         (txd_tvalid),
      .txd_tready         (txd_tready),
      .tx_axis_mac_tdata  (tx_axis_mac_tdata),
      .tx_axis_mac_tkeep  (tx_axis_mac_tkeep),
      .tx_axis_mac_tlast  (tx_axis_mac_tlast),
      .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
      .tx_axis_mac_tready (tx_axis_mac_tready)
   );

   initial
      mm2s_clk = 1'b0;

   always #2 mm2s_clk = ~mm2s_clk;

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic next_rand_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++)
         b[i] = next_rand_bit();
      return b;
   endfunction

   task automatic add_test(input int idx, input string name, input logic [3:0] flag,
                           input logic [1:0] code, input int cs_begin, input int cs_insert,
                           input logic [15:0] init, input int len, input bit bp);
      test_name[idx]  = name;
      flag_tab[idx]   = flag;
      code_tab[idx]   = code;
      begin_tab[idx]  = cs_begin;
      insert_tab[idx] = cs_insert;
      init_tab[idx]   = init;
      len_tab[idx]    = len;
      bp_tab[idx]     = bp;
      beats_tab[idx]  = (len + 7) / 8;
      err_tab[idx]    = 0;
   endtask

   task automatic load_table();
      add_test(0, "pass_even", 4'hA, 2'b00, 34, 50, 16'h0000, 64, 0);
      add_test(1, "pass_odd", 4'hA, 2'b00, 34, 50, 16'h0000, 61, 0);
      add_test(2, "pass_short", 4'hA, 2'b00, 0, 0, 16'h0000, 13, 0);
      add_test(3, "tcp_odd", 4'hA, 2'b01, 34, 50, 16'h1234, 77, 0);
      add_test(4, "tcp_even", 4'hA, 2'b01, 34, 50, 16'hffff, 128, 0);
      add_test(5, "tcp_tiny", 4'hA, 2'b01, 34, 50, 16'h0000, 53, 0);
      add_test(6, "no_flag", 4'h5, 2'b01, 34, 50, 16'h4321, 90, 0);
      add_test(7, "bp_tcp", 4'hA, 2'b01, 34, 50, 16'hbeef, 99, 1);
      add_test(8, "bp_tcp_b2b", 4'hA, 2'b01, 34, 50, 16'h0001, 66, 1);
      add_test(9, "bp_pass", 4'hA, 2'b00, 34, 50, 16'h0000, 41, 1);
      add_test(10, "long_fill", 4'hA, 2'b01, 34, 50, 16'h5a5a, `TXC_BUF_DEPTH*8 - 96, 1);
      add_test(11, "mid_fill", 4'hA, 2'b01, 34, 50, 16'h0f0f, 1600, 1);
      add_test(12, "after_short", 4'hA, 2'b01, 34, 50, 16'h2222, 60, 0);
      add_test(13, "after_pass", 4'hA, 2'b00, 34, 50, 16'h0000, 19, 0);
   endtask

   // Packs frame_bytes into beats, onto the input or the expected queues
   task automatic push_beats(input int len, input bit to_exp);
      tx_csum_pkg::beat_data_t d;
      tx_csum_pkg::beat_keep_t k;
      for (int b = 0; b < (len + 7) / 8; b++)
      begin
         d = '0;
         k = '0;
         for (int lane = 0; lane < 8; lane++)
         begin
            if (b * 8 + lane < len)
            begin
               d[8*lane +: 8] = frame_bytes[b * 8 + lane];
               k[lane] = 1'b1;
            end
         end
         if (to_exp)
         begin
            exp_data.push_back(d);
            exp_keep.push_back(k);
            exp_last.push_back((b + 1) * 8 >= len);
         end
         else
         begin
            in_data.push_back(d);
            in_keep.push_back(k);
            in_last.push_back((b + 1) * 8 >= len);
         end
      end
   endtask

   // Reference model of the ones'-complement checksum and its insertion
   task automatic build_frame(input int idx);
      logic [31:0] sum;
      logic [15:0] csum;
      int          len;
      int          ins;
      len = len_tab[idx];
      ins = insert_tab[idx];
      for (int i = 0; i < len; i++)
         frame_bytes[i] = rand_byte();
      frame_bytes[ins] = 8'h00;
      frame_bytes[ins + 1] = 8'h00;
      push_beats(len, 1'b0);
      if ((flag_tab[idx] == `TXC_FLAG) && (code_tab[idx] == `TXC_CS_FULL))
      begin
         sum = {16'h0000, init_tab[idx]};
         for (int off = begin_tab[idx]; off < len; off += 2)
         begin
            sum = sum + {frame_bytes[off], (off + 1 < len) ? frame_bytes[off + 1] : 8'h00};
            sum = (sum & 32'h0000_ffff) + (sum >> 16);
         end
         csum = ~sum[15:0];
         frame_bytes[ins] = csum[15:8];
         frame_bytes[ins + 1] = csum[7:0];
      end
      push_beats(len, 1'b1);
   endtask

   task automatic send_ctrl(input int idx);
      tx_csum_pkg::ctrl_word_t words [6];
      words[0] = {flag_tab[idx], 28'h0};
      words[1] = {30'h0, code_tab[idx]};
      words[2] = {begin_tab[idx][15:0], insert_tab[idx][15:0]};
      words[3] = {16'h0000, init_tab[idx]};
      words[4] = '0;
      words[5] = '0;
      for (int w = 0; w < `TXC_CTRL_WORDS; w++)
      begin
         txc_tdata = words[w];
         txc_tlast = (w == `TXC_CTRL_WORDS - 1);
         txc_tvalid = 1'b1;
         @(posedge mm2s_clk);
         while (!txc_tready)
            @(posedge mm2s_clk);
         @(negedge mm2s_clk);
      end
      txc_tvalid = 1'b0;
      txc_tlast = 1'b0;
   endtask

   // Stalls inside a frame can only come from a full buffer
   task automatic send_data(input int idx);
      for (int b = 0; b < beats_tab[idx]; b++)
      begin
         txd_tdata = in_data.pop_front();
         txd_tkeep = in_keep.pop_front();
         txd_tlast = in_last.pop_front();
         txd_tvalid = 1'b1;
         @(posedge mm2s_clk);
         while (!txd_tready)
         begin
            if (b > 0)
               stall_cycles++;
            @(posedge mm2s_clk);
         end
         @(negedge mm2s_clk);
      end
      txd_tvalid = 1'b0;
      txd_tlast = 1'b0;
   endtask

   always @(negedge mm2s_clk)
   begin
      if ((out_frame < NUM_TESTS) && bp_tab[out_frame])
         tx_axis_mac_tready = next_rand_bit();
      else
         tx_axis_mac_tready = 1'b1;
   end

   always @(posedge mm2s_clk)
   begin
      if (!rst && tx_axis_mac_tvalid && tx_axis_mac_tready)
      begin
         if (exp_data.size() == 0)
         begin
            $display("output beat seen after the last expected frame");
            error_cnt++;
         end
         else
         begin
            want_data = exp_data.pop_front();
            want_keep = exp_keep.pop_front();
            want_last = exp_last.pop_front();
            assert (tx_axis_mac_tdata == want_data)
            else
            begin
               $display("ERR %s beat %0d tdata expected %h actual %h", test_name[out_frame],
                        out_beat, want_data, tx_axis_mac_tdata);
               err_tab[out_frame]++;
            end
            assert (tx_axis_mac_tkeep == want_keep)
            else
            begin
               $display("ERR %s beat %0d tkeep expected %h actual %h", test_name[out_frame],
                        out_beat, want_keep, tx_axis_mac_tkeep);
               err_tab[out_frame]++;
            end
            assert (tx_axis_mac_tlast == want_last)
            else
            begin
               $display("ERR %s beat %0d tlast expected %b actual %b", test_name[out_frame],
                        out_beat, want_last, tx_axis_mac_tlast);
               err_tab[out_frame]++;
            end
            check_cnt += 3;
            out_beat++;
            if (want_last)
            begin
               $display("%-12s beats %0d errors %0d", test_name[out_frame], out_beat,
                        err_tab[out_frame]);
               error_cnt += err_tab[out_frame];
               out_frame++;
               out_beat = 0;
            end
         end
      end
   end

   always @(posedge mm2s_clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > timeout_limit)
      begin
         $display("timeout after %0d cycles with %0d of %0d frames received",
                  cycle_cnt, out_frame, NUM_TESTS);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial
   begin
      rst = 1'b1;
      txc_tdata = '0;
      txc_tkeep = 4'hf;
      txc_tlast = 1'b0;
      txc_tvalid = 1'b0;
      txd_tdata = '0;
      txd_tkeep = '0;
      txd_tlast = 1'b0;
      txd_tvalid = 1'b0;
      tx_axis_mac_tready = 1'b1;
      load_table();
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         build_frame(i);
         total_beats += beats_tab[i];
      end
      timeout_limit = 4 * total_beats + 64 * NUM_TESTS;

      repeat (8) @(negedge mm2s_clk);
      rst = 1'b0;
      // Idle outputs straight out of reset
      assert (!tx_axis_mac_tvalid && txc_tready)
      else
      begin
         $display("outputs not idle after reset, tvalid %b txc_tready %b",
                  tx_axis_mac_tvalid, txc_tready);
         error_cnt++;
      end
      check_cnt++;

      for (int i = 0; i < NUM_TESTS; i++)
      begin
         send_ctrl(i);
         send_data(i);
      end
      wait (out_frame == NUM_TESTS);
      repeat (8) @(posedge mm2s_clk);

      assert (stall_cycles > 0)
      else
      begin
         $display("input never stalled on a full buffer during the long frames");
         error_cnt++;
      end
      check_cnt++;
      if (i_tx_csum_offload.i_frame_emitter.i_emitter_assertions.fail_cnt != 0)
      begin
         $display("stream rule assertions failed %0d times",
                  i_tx_csum_offload.i_frame_emitter.i_emitter_assertions.fail_cnt);
         error_cnt++;
      end

      $display("tests %0d checks %0d errors %0d stall cycles %0d",
               NUM_TESTS, check_cnt, error_cnt, stall_cycles);
      if (error_cnt == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* src.f */
+incdir+design
design/tx_csum_pkg.sv
design/txc_parser.sv
design/frame_buffer.sv
design/csum_engine.sv
design/frame_emitter.sv
design/tx_csum_offload.sv
dv/tx_csum_offload_assertions.sv
dv/tx_csum_offload_tb.sv
